// File: hw/blur_mask_defs.svh
// Frame geometry, pixel width, mask threshold and frame store depth
`ifndef BLUR_MASK_DEFS_SVH
`define BLUR_MASK_DEFS_SVH

// Pixels in one column, top row first
`define FRAME_ROWS 8

// Columns in one frame, fetched left to right
`define FRAME_COLS 16

// Width of one grey pixel
`define PIXEL_BITS 8

// A mask bit is set when the blurred value is strictly above this
`define BLUR_THRESHOLD 32

// One frame store entry per pixel
`define MEM_DEPTH (`FRAME_ROWS * `FRAME_COLS)

`endif

// File: hw/blur_mask_pkg.sv
// Pixel, column, mask, address and index types plus the fetch state and store owner enums
`default_nettype none

`include "blur_mask_defs.svh"

package blur_mask_pkg;

  typedef logic [`PIXEL_BITS-1:0] pixel_t;

  // Host pixel: red in the top byte, green in the middle, blue in the low byte
  typedef logic [3*`PIXEL_BITS-1:0] rgb_t;

  // Row 0 sits in the low slot
  typedef pixel_t [`FRAME_ROWS-1:0] column_t;

  typedef logic [`FRAME_ROWS-1:0] mask_t;

  // Address is column * FRAME_ROWS + row
  typedef logic [$clog2(`MEM_DEPTH)-1:0] mem_addr_t;
  typedef logic [$clog2(`FRAME_COLS)-1:0] col_idx_t;
  typedef logic [$clog2(`FRAME_ROWS)-1:0] row_idx_t;

  typedef enum logic [1:0] {FETCH_IDLE, FETCH_READ, FETCH_EMIT} fetch_state_e;

  // Which requester the frame store served in the previous cycle
  typedef enum logic [1:0] {OWNER_NONE, OWNER_LOADER, OWNER_FETCH} mem_owner_e;

endpackage

`default_nettype wire

// File: hw/mem_port_if.sv
// Interface for one requester's port to the shared frame store
`timescale 1ns/1ns
`default_nettype none

interface mem_port_if import blur_mask_pkg::*; ();

  // Request side, held until the cycle where req and gnt are both high
  logic      req;
  logic      we;
  mem_addr_t addr;
  pixel_t    wdata;

  // Arbiter side
  logic   gnt;
  pixel_t rdata;
  // Pulses one cycle after an accepted read
  logic   rdata_valid;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata, rdata_valid
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata, rdata_valid
  );

endinterface

`default_nettype wire

// File: hw/frame_memory.sv
// Single-port synchronous RAM holding one grey frame
`timescale 1ns/1ns
`default_nettype none

`include "blur_mask_defs.svh"

module frame_memory import blur_mask_pkg::*; (
  input  logic      clock,
  input  logic      enable,
  input  logic      write,
  input  mem_addr_t address,
  input  pixel_t    write_data,
  output pixel_t    read_data
);

  // One entry per pixel, column-major
  pixel_t storage [`MEM_DEPTH];

  // A read returns its data on the edge after the enabled cycle.
  // A write updates the entry at the edge and leaves read_data as it was
  always_ff @(posedge clock) begin
    if (enable) begin
      if (write) begin
        storage[address] <= write_data;
      end else begin
        read_data <= storage[address];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/mem_arbiter.sv
// Fixed-priority arbiter sharing the frame store between pixel loader and column fetcher
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter import blur_mask_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  mem_port_if.arbiter        load_port,
  mem_port_if.arbiter        fetch_port,
  output logic               mem_enable,
  output logic               mem_write,
  output mem_addr_t          mem_address,
  output pixel_t             mem_write_data,
  input  pixel_t             mem_read_data
);

  mem_owner_e read_owner;

  // The loader always wins, so a host write is never stalled
  assign load_port.gnt  = load_port.req;
  assign fetch_port.gnt = fetch_port.req && !load_port.req;

  always_comb begin
    mem_enable = load_port.gnt || fetch_port.gnt;
    if (load_port.gnt) begin
      mem_write      = load_port.we;
      mem_address    = load_port.addr;
      mem_write_data = load_port.wdata;
    end else begin
      mem_write      = fetch_port.gnt && fetch_port.we;
      mem_address    = fetch_port.addr;
      mem_write_data = fetch_port.wdata;
    end
  end

  // Remember who owned a read so its data goes back to the right port.
  // Writes return nothing and leave the record at none
  always_ff @(posedge clock) begin
    if (reset) begin
      read_owner <= OWNER_NONE;
    end else if (load_port.gnt && !load_port.we) begin
      read_owner <= OWNER_LOADER;
    end else if (fetch_port.gnt && !fetch_port.we) begin
      read_owner <= OWNER_FETCH;
    end else begin
      read_owner <= OWNER_NONE;
    end
  end

  assign load_port.rdata        = mem_read_data;
  assign fetch_port.rdata       = mem_read_data;
  assign load_port.rdata_valid  = (read_owner == OWNER_LOADER);
  assign fetch_port.rdata_valid = (read_owner == OWNER_FETCH);

  grants_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(load_port.gnt && fetch_port.gnt));

  // A stalled fetch request keeps its address until the arbiter grants it
  fetch_req_held: assert property (@(posedge clock) disable iff (reset)
    fetch_port.req && !fetch_port.gnt |=> fetch_port.req && $stable(fetch_port.addr));

endmodule

`default_nettype wire

// File: hw/pixel_loader.sv
// Host pixel loader with RGB to grey conversion and frame store write request
`timescale 1ns/1ns
`default_nettype none

`include "blur_mask_defs.svh"

module pixel_loader import blur_mask_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  input  logic           pix_write,
  input  col_idx_t       pix_col,
  input  row_idx_t       pix_row,
  input  rgb_t           pix_rgb,
  mem_port_if.requester  mem
);

  pixel_t red;
  pixel_t green;
  pixel_t blue;
  pixel_t grey;

  assign red   = pix_rgb[3*`PIXEL_BITS-1:2*`PIXEL_BITS];
  assign green = pix_rgb[2*`PIXEL_BITS-1:`PIXEL_BITS];
  assign blue  = pix_rgb[`PIXEL_BITS-1:0];

  // Each term is truncated before the sum, so the total stays below 256
  assign grey = (red >> 2) + (green >> 1) + (blue >> 2);

  always_ff @(posedge clock) begin
    if (reset) begin
      mem.req <= 1'b0;
    end else if (pix_write) begin
      mem.req <= 1'b1;
    end else if (mem.gnt) begin
      mem.req <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (pix_write) begin
      mem.addr  <= mem_addr_t'(int'(pix_col) * `FRAME_ROWS + int'(pix_row));
      mem.wdata <= grey;
    end
  end

  assign mem.we = 1'b1;

  // The host must not overwrite a pixel that the arbiter has not taken yet
  no_write_while_pending: assert property (@(posedge clock) disable iff (reset)
    pix_write |-> !(mem.req && !mem.gnt));

endmodule

`default_nettype wire

// File: hw/column_fetch.sv
// Column fetch sequencer reading the frame store one column at a time plus a closing zero column
`timescale 1ns/1ns
`default_nettype none

`include "blur_mask_defs.svh"

module column_fetch import blur_mask_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  input  logic           start,
  output logic           busy,
  mem_port_if.requester  mem,
  output column_t        column,
  output logic           column_strobe,
  output logic           column_pad
);

  localparam row_idx_t LAST_ROW = row_idx_t'(`FRAME_ROWS - 1);
  localparam col_idx_t LAST_COL = col_idx_t'(`FRAME_COLS - 1);

  fetch_state_e state;
  col_idx_t     col;
  // Next row to request and next row to come back
  row_idx_t     req_row;
  row_idx_t     ret_row;
  logic         read_pending;
  // Set while the closing zero column is being emitted
  logic         pad;

  assign mem.req   = read_pending;
  assign mem.we    = 1'b0;
  assign mem.wdata = '0;
  assign mem.addr  = mem_addr_t'(int'(col) * `FRAME_ROWS + int'(req_row));

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= FETCH_IDLE;
      col          <= '0;
      req_row      <= '0;
      ret_row      <= '0;
      read_pending <= 1'b0;
      pad          <= 1'b0;
    end else begin
      case (state)
        FETCH_IDLE: begin
          if (start) begin
            state        <= FETCH_READ;
            col          <= '0;
            req_row      <= '0;
            ret_row      <= '0;
            read_pending <= 1'b1;
            pad          <= 1'b0;
          end
        end
        FETCH_READ: begin
          // Requests and returns run on their own counters since the loader can stall us
          if (mem.req && mem.gnt) begin
            if (req_row == LAST_ROW) begin
              read_pending <= 1'b0;
            end else begin
              req_row <= req_row + 1'b1;
            end
          end
          if (mem.rdata_valid) begin
            if (ret_row == LAST_ROW) begin
              ret_row <= '0;
              state   <= FETCH_EMIT;
            end else begin
              ret_row <= ret_row + 1'b1;
            end
          end
        end
        FETCH_EMIT: begin
          if (pad) begin
            pad   <= 1'b0;
            state <= FETCH_IDLE;
          end else if (col == LAST_COL) begin
            // Stay in emit for one more strobe, this time with the zero column
            pad <= 1'b1;
          end else begin
            col          <= col + 1'b1;
            req_row      <= '0;
            read_pending <= 1'b1;
            state        <= FETCH_READ;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == FETCH_READ && mem.rdata_valid) begin
      column[ret_row] <= mem.rdata;
    end else if (state == FETCH_EMIT && !pad && col == LAST_COL) begin
      column <= '0;
    end
  end

  assign busy          = (state != FETCH_IDLE);
  assign column_strobe = (state == FETCH_EMIT);
  assign column_pad    = (state == FETCH_EMIT) && pad;

endmodule

`default_nettype wire

// File: hw/blur_mask_stage.sv
// Three-column window with 3x3 shift-weighted blur, threshold and mask output strobes
`timescale 1ns/1ns
`default_nettype none

`include "blur_mask_defs.svh"

module blur_mask_stage import blur_mask_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  column_t  column,
  input  logic     column_strobe,
  input  logic     column_pad,
  output logic     mask_valid,
  output col_idx_t mask_col,
  output mask_t    mask_bits,
  output logic     done
);

  // Wide enough for the worst case sum of all nine weighted terms
  typedef logic [`PIXEL_BITS+1:0] sum_t;

  column_t  left_col;
  column_t  centre_col;
  logic     first;
  col_idx_t out_count;

  // Zero rows above the top and below the bottom, so row r sits at index r + 1
  pixel_t [`FRAME_ROWS+1:0] left_pad;
  pixel_t [`FRAME_ROWS+1:0] centre_pad;
  pixel_t [`FRAME_ROWS+1:0] right_pad;

  sum_t  blur_sum [`FRAME_ROWS];
  mask_t mask_next;

  assign left_pad   = {pixel_t'(0), left_col, pixel_t'(0)};
  assign centre_pad = {pixel_t'(0), centre_col, pixel_t'(0)};
  assign right_pad  = {pixel_t'(0), column, pixel_t'(0)};

  // Corners weigh 1/16, edge neighbours 1/8 and the centre 1/4
  always_comb begin
    for (int r = 1; r <= `FRAME_ROWS; r++) begin
      blur_sum[r-1] = sum_t'(left_pad[r-1] >> 4) + sum_t'(left_pad[r] >> 3)
                    + sum_t'(left_pad[r+1] >> 4) + sum_t'(centre_pad[r-1] >> 3)
                    + sum_t'(centre_pad[r] >> 2) + sum_t'(centre_pad[r+1] >> 3)
                    + sum_t'(right_pad[r-1] >> 4) + sum_t'(right_pad[r] >> 3)
                    + sum_t'(right_pad[r+1] >> 4);
      mask_next[r-1] = (blur_sum[r-1] > sum_t'(`BLUR_THRESHOLD));
    end
  end

  // The first strobe of a run only fills the window, every later one produces a mask
  always_ff @(posedge clock) begin
    if (reset) begin
      first      <= 1'b1;
      out_count  <= '0;
      mask_valid <= 1'b0;
      mask_col   <= '0;
      done       <= 1'b0;
    end else begin
      mask_valid <= column_strobe && !first;
      done       <= column_strobe && !first && column_pad;
      if (column_strobe) begin
        if (first) begin
          first <= 1'b0;
        end else begin
          mask_col  <= out_count;
          out_count <= out_count + 1'b1;
          if (column_pad) begin
            first     <= 1'b1;
            out_count <= '0;
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (column_strobe) begin
      // Column 0 has nothing to its left
      left_col   <= first ? column_t'(0) : centre_col;
      centre_col <= column;
      mask_bits  <= mask_next;
    end
  end

  mask_col_in_range: assert property (@(posedge clock) disable iff (reset)
    mask_valid |-> (int'(mask_col) <= `FRAME_COLS - 1));

  // The fetcher's pad column must land exactly on the last frame column
  done_on_last_col: assert property (@(posedge clock) disable iff (reset)
    done |-> mask_valid && (int'(mask_col) == `FRAME_COLS - 1));

endmodule

`default_nettype wire

// File: hw/blur_mask_top.sv
// Top level joining the pixel loader, column fetcher, arbiter, frame store and blur mask stage
`timescale 1ns/1ns
`default_nettype none

module blur_mask_top import blur_mask_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     pix_write,
  input  col_idx_t pix_col,
  input  row_idx_t pix_row,
  input  rgb_t     pix_rgb,
  input  logic     start,
  output logic     busy,
  output logic     mask_valid,
  output col_idx_t mask_col,
  output mask_t    mask_bits,
  output logic     done
);

  mem_port_if load_port ();
  mem_port_if fetch_port ();

  logic      mem_enable;
  logic      mem_write;
  mem_addr_t mem_address;
  pixel_t    mem_write_data;
  pixel_t    mem_read_data;

  column_t   column;
  logic      column_strobe;
  logic      column_pad;

  pixel_loader loader_i (
    .clock     (clock),
    .reset     (reset),
    .pix_write (pix_write),
    .pix_col   (pix_col),
    .pix_row   (pix_row),
    .pix_rgb   (pix_rgb),
    .mem       (load_port)
  );

  column_fetch fetch_i (
    .clock         (clock),
    .reset         (reset),
    .start         (start),
    .busy          (busy),
    .mem           (fetch_port),
    .column        (column),
    .column_strobe (column_strobe),
    .column_pad    (column_pad)
  );

  mem_arbiter arbiter_i (
    .clock          (clock),
    .reset          (reset),
    .load_port      (load_port),
    .fetch_port     (fetch_port),
    .mem_enable     (mem_enable),
    .mem_write      (mem_write),
    .mem_address    (mem_address),
    .mem_write_data (mem_write_data),
    .mem_read_data  (mem_read_data)
  );

  frame_memory memory_i (
    .clock      (clock),
    .enable     (mem_enable),
    .write      (mem_write),
    .address    (mem_address),
    .write_data (mem_write_data),
    .read_data  (mem_read_data)
  );

  blur_mask_stage stage_i (
    .clock         (clock),
    .reset         (reset),
    .column        (column),
    .column_strobe (column_strobe),
    .column_pad    (column_pad),
    .mask_valid    (mask_valid),
    .mask_col      (mask_col),
    .mask_bits     (mask_bits),
    .done          (done)
  );

endmodule

`default_nettype wire

// File: testbench/blur_mask_tb.sv
// Table-driven testbench for blur_mask_top with frame model, LFSR stimulus, checks and watchdog
`timescale 1ns/1ns
`default_nettype none

`include "blur_mask_defs.svh"

module blur_mask_tb import blur_mask_pkg::*; ();

  localparam int CLOCK_PERIOD = 100;
  localparam int NUM_TESTS = 7;
  localparam int KIND_ZERO = 0;
  localparam int KIND_SINGLE = 1;
  localparam int KIND_RANDOM = 2;
  localparam int WATCHDOG_CYCLES =
    NUM_TESTS * (`FRAME_COLS * (`FRAME_ROWS + 2) * 4 + 200);

  typedef struct {
    string name;
    int    kind;
    int    bright_col;
    int    bright_row;
    bit    rewrite;
    bit    extra_start;
    bit    mid_reset;
  } test_entry_t;

  // Pattern, bright pixel position, host rewrites, extra start, reset mid-run
  test_entry_t tests [NUM_TESTS] = '{
    '{"all black",             KIND_ZERO,   0,  0, 1'b0, 1'b0, 1'b0},
    '{"white pixel top left",  KIND_SINGLE, 0,  0, 1'b0, 1'b0, 1'b0},
    '{"white pixel far corner", KIND_SINGLE, `FRAME_COLS - 1, `FRAME_ROWS - 1, 1'b0, 1'b0, 1'b0},
    '{"white pixel centre",    KIND_SINGLE, 7,  4, 1'b0, 1'b0, 1'b0},
    '{"random frame",          KIND_RANDOM, 0,  0, 1'b0, 1'b0, 1'b0},
    '{"random with rewrites",  KIND_RANDOM, 0,  0, 1'b1, 1'b0, 1'b0},
    '{"random, restart, reset", KIND_RANDOM, 0, 0, 1'b1, 1'b1, 1'b1}
  };

  logic     clock;
  logic     reset;
  logic     pix_write;
  col_idx_t pix_col;
  row_idx_t pix_row;
  rgb_t     pix_rgb;
  logic     start;
  logic     busy;
  logic     mask_valid;
  col_idx_t mask_col;
  mask_t    mask_bits;
  logic     done;

  logic [15:0] lfsr = 16'd43;
  rgb_t        frame_rgb [`FRAME_COLS][`FRAME_ROWS];
  int          frame_grey [`FRAME_COLS][`FRAME_ROWS];
  int          error_count = 0;
  int          pass_count = 0;
  int          fail_count = 0;

  blur_mask_top dut_i (
    .clock      (clock),
    .reset      (reset),
    .pix_write  (pix_write),
    .pix_col    (pix_col),
    .pix_row    (pix_row),
    .pix_rgb    (pix_rgb),
    .start      (start),
    .busy       (busy),
    .mask_valid (mask_valid),
    .mask_col   (mask_col),
    .mask_bits  (mask_bits),
    .done       (done)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  // Taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic take_bits(input int count, output rgb_t value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr = lfsr_step(lfsr);
      value = {value[22:0], lfsr[0]};
    end
  endtask

  function automatic int grey_of(input rgb_t rgb);
    return int'(rgb[23:16] >> 2) + int'(rgb[15:8] >> 1) + int'(rgb[7:0] >> 2);
  endfunction

  // Pixels outside the frame count as zero
  function automatic int pixel_at(input int c, input int r);
    if (c < 0 || c >= `FRAME_COLS || r < 0 || r >= `FRAME_ROWS) begin
      return 0;
    end
    return frame_grey[c][r];
  endfunction

  function automatic mask_t expected_mask(input int c);
    mask_t bits;
    int    sum;
    int    shift;
    for (int r = 0; r < `FRAME_ROWS; r++) begin
      sum = 0;
      for (int dc = -1; dc <= 1; dc++) begin
        for (int dr = -1; dr <= 1; dr++) begin
          shift = (dc == 0 && dr == 0) ? 2 : ((dc == 0 || dr == 0) ? 3 : 4);
          sum += pixel_at(c + dc, r + dr) >> shift;
        end
      end
      bits[r] = (sum > `BLUR_THRESHOLD);
    end
    return bits;
  endfunction

  task automatic check_value(input string name, input int got, input int expected);
    if (got != expected) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
      error_count++;
    end
  endtask

  task automatic drive_write(input int c, input int r, input rgb_t rgb);
    pix_write = 1'b1;
    pix_col = col_idx_t'(c);
    pix_row = row_idx_t'(r);
    pix_rgb = rgb;
  endtask

  task automatic apply_reset(input int cycles);
    reset = 1'b1;
    start = 1'b0;
    pix_write = 1'b0;
    repeat (cycles) begin
      @(posedge clock);
      #5;
    end
    check_value("busy", int'(busy), 0);
    check_value("mask_valid", int'(mask_valid), 0);
    check_value("done", int'(done), 0);
    reset = 1'b0;
  endtask

  task automatic load_frame(input int kind, input int bright_col, input int bright_row);
    rgb_t rgb;
    for (int c = 0; c < `FRAME_COLS; c++) begin
      for (int r = 0; r < `FRAME_ROWS; r++) begin
        if (kind == KIND_RANDOM) begin
          take_bits(24, rgb);
        end else if (kind == KIND_SINGLE && c == bright_col && r == bright_row) begin
          rgb = 24'hffffff;
        end else begin
          rgb = '0;
        end
        frame_rgb[c][r] = rgb;
        frame_grey[c][r] = grey_of(rgb);
        drive_write(c, r, rgb);
        @(posedge clock);
        #5;
      end
    end
    pix_write = 1'b0;
    repeat (3) begin
      @(posedge clock);
      #5;
    end
  endtask

  // Runs one frame and checks every mask output; a nonzero abort_cycle stops it early
  task automatic run_frame(input bit rewrite, input bit extra_start, input int abort_cycle,
                           input bit single_pixel);
    int cycle;
    int outputs;
    int dones;
    int set_bits;
    int wr_index;
    int tail;
    cycle = 0;
    outputs = 0;
    dones = 0;
    set_bits = 0;
    wr_index = 0;
    tail = 0;
    start = 1'b1;
    while (tail < 20) begin
      @(posedge clock);
      #5;
      cycle++;
      start = extra_start && cycle == 30;
      pix_write = 1'b0;
      if (mask_valid) begin
        if (outputs >= `FRAME_COLS) begin
          $display("more mask outputs than frame columns in one run");
          error_count++;
        end else begin
          check_value("mask_col", int'(mask_col), outputs);
          check_value("mask_bits", int'(mask_bits), int'(expected_mask(outputs)));
          check_value("done", int'(done), int'(outputs == `FRAME_COLS - 1));
        end
        set_bits += $countones(mask_bits);
        outputs++;
      end else if (done) begin
        $display("done pulsed without a mask output");
        error_count++;
      end
      if (done) begin
        dones++;
      end
      // The fetcher is busy from the cycle after start until done appears
      check_value("busy", int'(busy), int'(dones == 0));
      if (dones > 0) begin
        tail++;
      end
      if (abort_cycle > 0 && cycle == abort_cycle) begin
        return;
      end
      // The host keeps rewriting the same frame, one pixel every third cycle
      if (rewrite && dones == 0 && cycle % 3 == 0) begin
        drive_write(wr_index / `FRAME_ROWS, wr_index % `FRAME_ROWS,
                    frame_rgb[wr_index / `FRAME_ROWS][wr_index % `FRAME_ROWS]);
        wr_index = (wr_index + 1) % `MEM_DEPTH;
      end
    end
    check_value("mask output count", outputs, `FRAME_COLS);
    check_value("done count", dones, 1);
    if (single_pixel) begin
      check_value("mask bit count", set_bits, 1);
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("timeout after %0d clock cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int errors_before;
    clock = 1'b0;
    reset = 1'b1;
    pix_write = 1'b0;
    pix_col = '0;
    pix_row = '0;
    pix_rgb = '0;
    start = 1'b0;
    apply_reset(16);
    for (int i = 0; i < NUM_TESTS; i++) begin
      errors_before = error_count;
      load_frame(tests[i].kind, tests[i].bright_col, tests[i].bright_row);
      if (tests[i].mid_reset) begin
        run_frame(1'b0, tests[i].extra_start, 60, 1'b0);
        apply_reset(4);
      end
      run_frame(tests[i].rewrite, tests[i].extra_start, 0, tests[i].kind == KIND_SINGLE);
      if (error_count == errors_before) begin
        pass_count++;
        $display("test %0d (%s) passed", i, tests[i].name);
      end else begin
        fail_count++;
        $display("test %0d (%s) failed with %0d errors", i, tests[i].name,
                 error_count - errors_before);
      end
    end
    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: blur_mask_top.f
+incdir+hw
hw/blur_mask_pkg.sv
hw/mem_port_if.sv
hw/frame_memory.sv
hw/mem_arbiter.sv
hw/pixel_loader.sv
hw/column_fetch.sv
hw/blur_mask_stage.sv
hw/blur_mask_top.sv
testbench/blur_mask_tb.sv

// File: Makefile
TOP = blur_mask_tb

.PHONY: run clean

run:
	verilator --binary --timing --assert -f blur_mask_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
